// ==== common/lsu_bus_pkg.sv ====
// data bus word, byte-lane mask and byte offset types
`include "lsu_macros.svh"

package lsu_bus_pkg;

  // one full bus word, also used for register data
  typedef logic [`LSU_XLEN-1:0] word_t;

  // one bit per byte lane, bit 0 is the lowest byte
  typedef logic [`LSU_LANES-1:0] lane_mask_t;

  // byte position inside a word
  typedef logic [$clog2(`LSU_LANES)-1:0] byte_ofs_t;

endpackage

// ==== common/lsu_macros.svh ====
// load/store unit widths and constants shared by the design and the testbench
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN 32

// byte lanes on the data bus
`define LSU_LANES 4

// instruction order tag carried from dispatch to retire
`define LSU_ORDER_W 64

// register file index width
`define LSU_REG_IDX_W 5

// offset immediate, sign extended to LSU_XLEN before the address add
`define LSU_IMM_W 12

`define LSU_PC_STEP 4

`endif

// ==== common/lsu_op_pkg.sv ====
// operation encodings and access sizes of the load/store unit
package lsu_op_pkg;

  // OP_NONE and every unlisted code are treated as an invalid instruction
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LH   = 4'd2,
    OP_LW   = 4'd3,
    OP_LBU  = 4'd4,
    OP_LHU  = 4'd5,
    OP_SB   = 4'd6,
    OP_SH   = 4'd7,
    OP_SW   = 4'd8
  } lsu_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  function automatic logic op_is_load(lsu_op_e op);
    return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
  endfunction

  function automatic logic op_is_store(lsu_op_e op);
    return op inside {OP_SB, OP_SH, OP_SW};
  endfunction

  function automatic lsu_size_e op_size(lsu_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return SIZE_BYTE;
      OP_LH, OP_LHU, OP_SH: return SIZE_HALF;
      default: return SIZE_WORD;
    endcase
  endfunction

endpackage

// ==== design/lsu_top.sv ====
// load/store unit top, joins the control FSM with the bus request and load datapaths
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      dpu_vld,
  input  lsu_op_e                   dpu_op,
  input  logic [`LSU_ORDER_W-1:0]   dpu_order,
  input  logic [`LSU_XLEN-1:0]      dpu_pc,
  input  logic [`LSU_REG_IDX_W-1:0] dpu_rd,
  input  logic [`LSU_XLEN-1:0]      dpu_rs1_data,
  input  logic [`LSU_XLEN-1:0]      dpu_rs2_data,
  input  logic [`LSU_IMM_W-1:0]     dpu_imm,
  input  logic                      bus_ack,
  input  logic [`LSU_XLEN-1:0]      bus_data_rd,
  output logic                      lsu_vld,
  output logic [`LSU_ORDER_W-1:0]   lsu_order,
  output logic                      lsu_retired,
  output logic                      lsu_freeze,
  output logic                      lsu_trap,
  output logic [`LSU_XLEN-1:0]      lsu_pc,
  output logic [`LSU_XLEN-1:0]      lsu_pc_next,
  output logic [`LSU_REG_IDX_W-1:0] lsu_rd,
  output logic                      lsu_rd_wr,
  output logic [`LSU_XLEN-1:0]      lsu_rd_data,
  output logic                      bus_req,
  output logic                      bus_write,
  output logic [`LSU_XLEN-1:0]      bus_addr,
  output logic [`LSU_LANES-1:0]     bus_data_rd_mask,
  output logic [`LSU_XLEN-1:0]      bus_data_wr,
  output logic [`LSU_LANES-1:0]     bus_data_wr_mask
);

  // captured instruction fields handed to the datapaths
  lsu_op_e                   op;
  word_t                     rs1_data;
  word_t                     rs2_data;
  logic [`LSU_IMM_W-1:0]     imm;
  logic                      issue;
  logic                      load_done;
  byte_ofs_t                 byte_ofs;

  lsu_ctrl lsu_ctrl_inst (.*);

  lsu_bus_req_gen lsu_bus_req_gen_inst (.*);

  // the destination index comes from the retiring instruction record
  lsu_load_extract lsu_load_extract_inst (
    .rd (lsu_rd),
    .*
  );

endmodule

// ==== flist.f ====
+incdir+common
common/lsu_op_pkg.sv
common/lsu_bus_pkg.sv
lsu/lsu_ctrl.sv
lsu/lsu_bus_req_gen.sv
lsu/lsu_load_extract.sv
design/lsu_top.sv
testbench/tb_bus_mem.sv
testbench/tb_lsu.sv

// ==== lsu/lsu_bus_req_gen.sv ====
// bus request generator, computes the address, lane masks and aligned store data
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_bus_req_gen
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue,
  input  lsu_op_e               op,
  input  word_t                 rs1_data,
  input  word_t                 rs2_data,
  input  logic [`LSU_IMM_W-1:0] imm,
  output logic                  bus_req,
  output logic                  bus_write,
  output word_t                 bus_addr,
  output lane_mask_t            bus_data_rd_mask,
  output word_t                 bus_data_wr,
  output lane_mask_t            bus_data_wr_mask,
  output byte_ofs_t             byte_ofs
);

  word_t      imm_ext;
  word_t      eff_addr;
  byte_ofs_t  ofs;
  byte_ofs_t  lane_sel;
  lane_mask_t lane_mask;
  word_t      shifted;
  word_t      wr_data;
  logic       is_store;

  assign imm_ext  = {{(`LSU_XLEN-`LSU_IMM_W){imm[`LSU_IMM_W-1]}}, imm};
  assign eff_addr = rs1_data + imm_ext;
  assign ofs      = eff_addr[1:0];
  assign is_store = op_is_store(op);

  // lowest lane touched and the lanes covered by the access
  always_comb
  begin
    case (op_size(op))
      SIZE_BYTE:
      begin
        lane_sel  = ofs;
        lane_mask = lane_mask_t'(1) << ofs;
      end
      SIZE_HALF:
      begin
        lane_sel  = {ofs[1], 1'b0};
        lane_mask = ofs[1] ? 4'b1100 : 4'b0011;
      end
      default:
      begin
        lane_sel  = '0;
        lane_mask = '1;
      end
    endcase
  end

  // move the low bytes of rs2 up to the first lane and clear unused lanes
  assign shifted = rs2_data << {lane_sel, 3'b000};

  always_comb
  begin
    for (int i = 0; i < `LSU_LANES; i++)
    begin
      wr_data[8*i +: 8] = lane_mask[i] ? shifted[8*i +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bus_req          <= 1'b0;
      bus_write        <= 1'b0;
      bus_addr         <= '0;
      bus_data_rd_mask <= '0;
      bus_data_wr      <= '0;
      bus_data_wr_mask <= '0;
      byte_ofs         <= '0;
    end
    else
    begin
      bus_req <= issue;
      // the rest stays put until the next issue
      if (issue)
      begin
        bus_write        <= is_store;
        bus_addr         <= {eff_addr[`LSU_XLEN-1:2], 2'b00};
        bus_data_rd_mask <= is_store ? '0 : lane_mask;
        bus_data_wr      <= is_store ? wr_data : '0;
        bus_data_wr_mask <= is_store ? lane_mask : '0;
        byte_ofs         <= ofs;
      end
    end
  end

endmodule

// ==== lsu/lsu_ctrl.sv ====
// load/store control, holds the instruction record and sequences issue, wait and retire
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_ctrl
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      dpu_vld,
  input  lsu_op_e                   dpu_op,
  input  logic [`LSU_ORDER_W-1:0]   dpu_order,
  input  logic [`LSU_XLEN-1:0]      dpu_pc,
  input  logic [`LSU_REG_IDX_W-1:0] dpu_rd,
  input  word_t                     dpu_rs1_data,
  input  word_t                     dpu_rs2_data,
  input  logic [`LSU_IMM_W-1:0]     dpu_imm,
  input  logic                      bus_ack,
  output logic                      lsu_vld,
  output logic [`LSU_ORDER_W-1:0]   lsu_order,
  output logic                      lsu_retired,
  output logic                      lsu_freeze,
  output logic                      lsu_trap,
  output logic [`LSU_XLEN-1:0]      lsu_pc,
  output logic [`LSU_XLEN-1:0]      lsu_pc_next,
  output logic [`LSU_REG_IDX_W-1:0] lsu_rd,
  output lsu_op_e                   op,
  output word_t                     rs1_data,
  output word_t                     rs2_data,
  output logic [`LSU_IMM_W-1:0]     imm,
  output logic                      issue,
  output logic                      load_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
  } ctrl_state_e;

  ctrl_state_e state;
  logic        accept;
  logic        op_valid;
  logic        pc_aligned;

  // a new instruction may enter while idle or in the cycle the previous one retires
  assign accept     = dpu_vld && (!lsu_vld || lsu_retired);
  assign op_valid   = op_is_load(op) || op_is_store(op);
  assign pc_aligned = (lsu_pc[1:0] == 2'b00);

  // a bad op or a misaligned PC never reaches the bus
  assign issue     = (state == ST_ISSUE) && op_valid && pc_aligned;
  assign load_done = (state == ST_WAIT) && bus_ack && op_is_load(op);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= ST_IDLE;
      lsu_vld     <= 1'b0;
      lsu_retired <= 1'b0;
      lsu_freeze  <= 1'b0;
      lsu_trap    <= 1'b0;
      lsu_pc_next <= '0;
    end
    else
    begin
      lsu_retired <= 1'b0;
      lsu_trap    <= 1'b0;
      case (state)
        ST_ISSUE:
        begin
          if (issue)
          begin
            state <= ST_WAIT;
          end
          else
          begin
            // retire straight away with a trap
            state       <= ST_IDLE;
            lsu_retired <= 1'b1;
            lsu_trap    <= 1'b1;
            lsu_freeze  <= 1'b0;
            lsu_pc_next <= lsu_pc + `LSU_XLEN'(`LSU_PC_STEP);
          end
        end
        ST_WAIT:
        begin
          if (bus_ack)
          begin
            state       <= ST_IDLE;
            lsu_retired <= 1'b1;
            lsu_freeze  <= 1'b0;
            lsu_pc_next <= lsu_pc + `LSU_XLEN'(`LSU_PC_STEP);
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase

      if (accept)
      begin
        state      <= ST_ISSUE;
        lsu_vld    <= 1'b1;
        lsu_freeze <= 1'b1;
      end
      else if (lsu_retired)
      begin
        lsu_vld <= 1'b0;
      end
    end
  end

  // instruction record, loaded once per accepted instruction
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      op        <= OP_NONE;
      lsu_order <= '0;
      lsu_pc    <= '0;
      lsu_rd    <= '0;
      rs1_data  <= '0;
      rs2_data  <= '0;
      imm       <= '0;
    end
    else if (accept)
    begin
      op        <= dpu_op;
      lsu_order <= dpu_order;
      lsu_pc    <= dpu_pc;
      lsu_rd    <= dpu_rd;
      rs1_data  <= dpu_rs1_data;
      rs2_data  <= dpu_rs2_data;
      imm       <= dpu_imm;
    end
  end

endmodule

// ==== lsu/lsu_load_extract.sv ====
// load data extraction, picks the lane, extends it and writes back the register
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_load_extract
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load_done,
  input  lsu_op_e                   op,
  input  logic [`LSU_REG_IDX_W-1:0] rd,
  input  byte_ofs_t                 byte_ofs,
  input  word_t                     bus_data_rd,
  output logic                      lsu_rd_wr,
  output word_t                     lsu_rd_data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  word_t       ext;

  assign byte_sel = bus_data_rd[{byte_ofs, 3'b000} +: 8];
  // halfword lanes follow the upper offset bit only
  assign half_sel = byte_ofs[1] ? bus_data_rd[31:16] : bus_data_rd[15:0];

  always_comb
  begin
    case (op)
      OP_LB:   ext = {{(`LSU_XLEN-8){byte_sel[7]}}, byte_sel};
      OP_LH:   ext = {{(`LSU_XLEN-16){half_sel[15]}}, half_sel};
      OP_LBU:  ext = {{(`LSU_XLEN-8){1'b0}}, byte_sel};
      OP_LHU:  ext = {{(`LSU_XLEN-16){1'b0}}, half_sel};
      default: ext = bus_data_rd;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lsu_rd_wr   <= 1'b0;
      lsu_rd_data <= '0;
    end
    else
    begin
      lsu_rd_wr <= load_done;
      if (load_done)
      begin
        // x0 always reads back as zero
        lsu_rd_data <= (rd == '0) ? '0 : ext;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f flist.f --top-module tb_lsu -o tb_lsu_sim

out=$(./obj_dir/tb_lsu_sim)
echo "$out"

if echo "$out" | grep -q "^Simulation passed$"; then
  exit 0
else
  exit 1
fi

// ==== testbench/tb_bus_mem.sv ====
// bus memory model, answers each request after a random delay and applies write lanes
`timescale 1ns/1ps

module tb_bus_mem
(
  input  logic        clk,
  input  logic        rst,
  input  logic        bus_req,
  input  logic        bus_write,
  input  logic [31:0] bus_addr,
  input  logic [31:0] bus_data_wr,
  input  logic [3:0]  bus_data_wr_mask,
  output logic        bus_ack,
  output logic [31:0] bus_data_rd
);

  logic [31:0] mem [16];
  logic [31:0] rng_state;
  int unsigned wait_cnt;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  initial
  begin
    rng_state   = 32'h76b21d64;
    bus_ack     = 1'b0;
    bus_data_rd = '0;
    wait_cnt    = 0;
    // every word differs, so a wrong index shows up in the data
    for (int i = 0; i < 16; i++)
    begin
      mem[i] = (32'h9e37_79b9 * 32'(i + 1)) ^ 32'h0f1e_2d3c;
    end
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      bus_ack  <= 1'b0;
      wait_cnt <= 0;
    end
    else
    begin
      bus_ack <= 1'b0;
      if (bus_req)
      begin
        wait_cnt <= 1 + (next_rand() % 4);
      end
      else if (wait_cnt == 1)
      begin
        // request outputs are still held, so they can be used at ack time
        bus_ack     <= 1'b1;
        bus_data_rd <= mem[bus_addr[5:2]];
        wait_cnt    <= 0;
        if (bus_write)
        begin
          for (int i = 0; i < 4; i++)
          begin
            if (bus_data_wr_mask[i])
            begin
              mem[bus_addr[5:2]][8*i +: 8] <= bus_data_wr[8*i +: 8];
            end
          end
        end
      end
      else if (wait_cnt > 1)
      begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

// ==== testbench/tb_lsu.sv ====
// load/store unit testbench with a reference memory, bus and retire checks
`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_lsu
  import lsu_op_pkg::*;
  import lsu_bus_pkg::*;
();

  localparam int N_INSTR = 37;

  logic                      clk;
  logic                      rst;
  logic                      dpu_vld;
  lsu_op_e                   dpu_op;
  logic [`LSU_ORDER_W-1:0]   dpu_order;
  logic [`LSU_XLEN-1:0]      dpu_pc;
  logic [`LSU_REG_IDX_W-1:0] dpu_rd;
  logic [`LSU_XLEN-1:0]      dpu_rs1_data;
  logic [`LSU_XLEN-1:0]      dpu_rs2_data;
  logic [`LSU_IMM_W-1:0]     dpu_imm;
  logic                      bus_ack;
  logic [`LSU_XLEN-1:0]      bus_data_rd;
  logic                      lsu_vld;
  logic [`LSU_ORDER_W-1:0]   lsu_order;
  logic                      lsu_retired;
  logic                      lsu_freeze;
  logic                      lsu_trap;
  logic [`LSU_XLEN-1:0]      lsu_pc;
  logic [`LSU_XLEN-1:0]      lsu_pc_next;
  logic [`LSU_REG_IDX_W-1:0] lsu_rd;
  logic                      lsu_rd_wr;
  logic [`LSU_XLEN-1:0]      lsu_rd_data;
  logic                      bus_req;
  logic                      bus_write;
  logic [`LSU_XLEN-1:0]      bus_addr;
  logic [`LSU_LANES-1:0]     bus_data_rd_mask;
  logic [`LSU_XLEN-1:0]      bus_data_wr;
  logic [`LSU_LANES-1:0]     bus_data_wr_mask;

  // instruction list in dispatch order
  logic [3:0]  op_l  [N_INSTR];
  logic [31:0] pc_l  [N_INSTR];
  logic [4:0]  rd_l  [N_INSTR];
  logic [31:0] rs1_l [N_INSTR];
  logic [31:0] rs2_l [N_INSTR];
  logic [11:0] imm_l [N_INSTR];
  logic [31:0] ref_mem [16];
  logic [31:0] rng_state;
  int          n_built;
  int          errors;
  int          checks;
  int          acc_count;
  int          retire_count;
  int          cur;
  int          age;
  logic        in_flight;
  logic        ack_prev;
  logic        rst_prev;

  lsu_top lsu_top_inst (.*);

  tb_bus_mem tb_bus_mem_inst (.*);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic is_load_op(logic [3:0] op);
    return op == OP_LB || op == OP_LH || op == OP_LW || op == OP_LBU || op == OP_LHU;
  endfunction

  function automatic logic is_store_op(logic [3:0] op);
    return op == OP_SB || op == OP_SH || op == OP_SW;
  endfunction

  function automatic logic goes_to_bus(int i);
    return (is_load_op(op_l[i]) || is_store_op(op_l[i])) && pc_l[i][1:0] == 2'b00;
  endfunction

  function automatic logic [31:0] eff_addr(int i);
    return rs1_l[i] + {{20{imm_l[i][11]}}, imm_l[i]};
  endfunction

  // 0 byte, 1 half, 2 word
  function automatic int access_size(logic [3:0] op);
    if (op == OP_LB || op == OP_LBU || op == OP_SB)
      return 0;
    if (op == OP_LH || op == OP_LHU || op == OP_SH)
      return 1;
    return 2;
  endfunction

  function automatic logic [3:0] lanes_of(logic [3:0] op, logic [1:0] ofs);
    case (access_size(op))
      0: return 4'b0001 << ofs;
      1: return ofs[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] place_store(logic [3:0] op, logic [1:0] ofs, logic [31:0] d);
    logic [3:0]  m;
    logic [31:0] r;
    int          first;
    m     = lanes_of(op, ofs);
    r     = '0;
    first = access_size(op) == 0 ? int'(ofs) : (access_size(op) == 1 ? 2 * int'(ofs[1]) : 0);
    for (int k = 0; k < 4; k++)
    begin
      if (m[k])
        r[8*k +: 8] = d[8*(k-first) +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] load_value(logic [3:0] op, logic [1:0] ofs, logic [31:0] w);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[{ofs, 3'b000} +: 8];
    h = ofs[1] ? w[31:16] : w[15:0];
    case (op)
      OP_LB:   return {{24{b[7]}}, b};
      OP_LH:   return {{16{h[15]}}, h};
      OP_LBU:  return {24'h0, b};
      OP_LHU:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  task automatic report_text(string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    assert (exp == act)
    else
    begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic add_instr(logic [3:0] op, logic [31:0] pc, logic [31:0] addr);
    logic [11:0] imm;
    imm              = 12'(next_rand() % 17) - 12'd8;
    op_l[n_built]    = op;
    pc_l[n_built]    = pc;
    rd_l[n_built]    = (n_built % 5 == 3) ? 5'd0 : 5'(1 + next_rand() % 31);
    imm_l[n_built]   = imm;
    rs1_l[n_built]   = addr - {{20{imm[11]}}, imm};
    rs2_l[n_built]   = next_rand();
    n_built++;
  endtask

  task automatic build_list();
    logic [3:0] seq [8];
    logic [31:0] w;
    seq = '{OP_SB, OP_SH, OP_SW, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    for (int o = 0; o < 4; o++)
    begin
      // one word per offset, so the loads see what the stores merged
      w = next_rand() % 16;
      for (int k = 0; k < 8; k++)
      begin
        add_instr(seq[k], 32'h100 + 32'(n_built * 4), w * 4 + 32'(o));
      end
    end
    add_instr(4'd0, 32'h200, 32'h4);
    add_instr(4'd9, 32'h204, 32'h8);
    add_instr(4'd15, 32'h208, 32'hc);
    add_instr(OP_LW, 32'h302, 32'h10);
    add_instr(OP_SW, 32'h305, 32'h14);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    #((N_INSTR * 8 + 100) * 40);
    $display("timeout: the instruction list did not retire in time");
    $display("Simulation failed");
    $finish;
  end

  assert property (@(posedge clk) disable iff (rst) bus_req |=> !bus_req)
  else report_text("bus_req was held high for more than one cycle");

  assert property (@(posedge clk) disable iff (rst) bus_ack |=> lsu_retired)
  else report_text("lsu_retired did not follow bus_ack by one cycle");

  always @(posedge clk)
  begin
    logic [31:0] ea;
    logic [3:0]  lanes;
    logic [31:0] st_word;
    ea      = eff_addr(cur);
    lanes   = lanes_of(op_l[cur], ea[1:0]);
    st_word = place_store(op_l[cur], ea[1:0], rs2_l[cur]);
    if (rst_prev)
    begin
      check_value("reset outputs", 64'd0,
        64'({lsu_vld, lsu_retired, lsu_freeze, lsu_trap, lsu_rd_wr, bus_req}));
    end
    if (!rst)
    begin
      if (in_flight)
        age++;
      if (in_flight && age == 1)
        check_value("busy after accept", 64'd3, 64'({lsu_vld, lsu_freeze}));
      if (in_flight && age == 2)
      begin
        check_value("bus_req timing", 64'(goes_to_bus(cur)), 64'(bus_req));
        if (!goes_to_bus(cur))
          check_value("trap retire", 64'd3, 64'({lsu_retired, lsu_trap}));
      end
      if (bus_req)
      begin
        if (!(in_flight && age == 2 && goes_to_bus(cur)))
          report_text("bus_req raised outside the issue slot");
        check_value("bus_addr", 64'({ea[31:2], 2'b00}), 64'(bus_addr));
        check_value("bus_write", 64'(is_store_op(op_l[cur])), 64'(bus_write));
        if (is_store_op(op_l[cur]))
        begin
          check_value("wr_mask", 64'(lanes), 64'(bus_data_wr_mask));
          check_value("wr_data", 64'(st_word), 64'(bus_data_wr));
        end
        else
        begin
          check_value("rd_mask", 64'(lanes), 64'(bus_data_rd_mask));
        end
      end
      if (lsu_trap && !lsu_retired)
        report_text("lsu_trap raised without lsu_retired");
      if (lsu_retired)
      begin
        if (!in_flight)
          report_text("lsu_retired with no instruction in flight");
        retire_count++;
        check_value("order", 64'(cur) + 64'h1000, lsu_order);
        check_value("rd", 64'(rd_l[cur]), 64'(lsu_rd));
        check_value("pc", 64'(pc_l[cur]), 64'(lsu_pc));
        check_value("pc_next", 64'(pc_l[cur] + 32'd4), 64'(lsu_pc_next));
        check_value("freeze at retire", 64'd0, 64'(lsu_freeze));
        check_value("trap", 64'(!goes_to_bus(cur)), 64'(lsu_trap));
        check_value("rd_wr", 64'(goes_to_bus(cur) && is_load_op(op_l[cur])), 64'(lsu_rd_wr));
        if (goes_to_bus(cur) && !ack_prev)
          report_text("lsu_retired without a preceding bus_ack");
        if (goes_to_bus(cur) && is_load_op(op_l[cur]))
        begin
          check_value("load data", rd_l[cur] == 5'd0 ? 64'd0 :
            64'(load_value(op_l[cur], ea[1:0], ref_mem[ea[5:2]])),
            64'(lsu_rd_data));
        end
        if (goes_to_bus(cur) && is_store_op(op_l[cur]))
        begin
          for (int k = 0; k < 4; k++)
          begin
            if (lanes[k])
              ref_mem[ea[5:2]][8*k +: 8] = st_word[8*k +: 8];
          end
        end
        in_flight = 1'b0;
      end
      if (dpu_vld && (!lsu_vld || lsu_retired))
      begin
        cur       = acc_count;
        acc_count++;
        age       = 0;
        in_flight = 1'b1;
      end
    end
    ack_prev = bus_ack;
    rst_prev = rst;
  end

  initial
  begin
    rng_state    = 32'h76b21d64;
    rst          = 1'b1;
    dpu_vld      = 1'b0;
    dpu_op       = OP_NONE;
    dpu_order    = '0;
    dpu_pc       = '0;
    dpu_rd       = '0;
    dpu_rs1_data = '0;
    dpu_rs2_data = '0;
    dpu_imm      = '0;
    n_built      = 0;
    errors       = 0;
    checks       = 0;
    acc_count    = 0;
    retire_count = 0;
    cur          = 0;
    age          = 0;
    in_flight    = 1'b0;
    ack_prev     = 1'b0;
    rst_prev     = 1'b0;
    for (int i = 0; i < 16; i++)
      ref_mem[i] = (32'h9e37_79b9 * 32'(i + 1)) ^ 32'h0f1e_2d3c;
    build_list();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < N_INSTR; i++)
    begin
      dpu_vld      <= 1'b1;
      dpu_op       <= lsu_op_e'(op_l[i]);
      dpu_order    <= 64'h1000 + 64'(i);
      dpu_pc       <= pc_l[i];
      dpu_rd       <= rd_l[i];
      dpu_rs1_data <= rs1_l[i];
      dpu_rs2_data <= rs2_l[i];
      dpu_imm      <= imm_l[i];
      do
        @(posedge clk);
      while (lsu_vld && !lsu_retired);
    end
    dpu_vld <= 1'b0;
    wait (retire_count == N_INSTR);
    repeat (4) @(posedge clk);
    check_value("retired count", 64'(N_INSTR), 64'(retire_count));
    $display("checks %0d, errors %0d, retired %0d", checks, errors, retire_count);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
